// File: issue_cluster.f
+incdir+verification
src/rs_pkg.sv
src/tag_ready_table.sv
src/rs.sv
src/fu_pipe.sv
src/cdb_arbiter.sv
src/issue_cluster.sv
verification/issue_cluster_tb.sv

// File: Bender.yml
package:
  name: issue_cluster

sources:
  - src/rs_pkg.sv
  - src/tag_ready_table.sv
  - src/rs.sv
  - src/fu_pipe.sv
  - src/cdb_arbiter.sv
  - src/issue_cluster.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/issue_cluster_tb.sv

// File: verification/issue_cluster_tests.svh
  function automatic dispatch_op_t make_op(fu_type_t fu, int dest, int src1, int src2);
    dispatch_op_t op;
    op.fu   = fu;
    op.func = func_width'(dest);  // never observed downstream
    op.dest = tag_width'(dest);
    op.src1 = tag_width'(src1);
    op.src2 = tag_width'(src2);
    return op;
  endfunction

  // raise dispatch_en for one op and record it in the scoreboard
  task automatic send_op(dispatch_op_t op, output int edge_idx);
    @(posedge clock);
    dispatch_en        <= 1'b1;
    dispatch           <= op;
    edge_idx           = cycle_cnt + 1;  // counter moves at this edge
    op_live[op.dest]   = 1'b1;
    wait1[op.dest]     = !tag_ready[op.src1];
    wait2[op.dest]     = !tag_ready[op.src2];
    op_src1[op.dest]   = op.src1;
    op_src2[op.dest]   = op.src2;
    tag_ready[op.dest] = 1'b0;
    live_count++;
  endtask

  // op on the bus with dispatch_en low so rs_hazard can be sampled
  task automatic present_op(dispatch_op_t op);
    @(posedge clock);
    dispatch_en <= 1'b0;
    dispatch    <= op;
  endtask

  task automatic idle_cycle();
    @(posedge clock);
    dispatch_en <= 1'b0;
  endtask

  // lands on the falling edge inside cycle n
  task automatic wait_until_cycle(int n);
    int guard = 0;
    while (cycle_cnt < n && guard < 50) begin
      @(negedge clock);
      guard++;
    end
    if (cycle_cnt < n) report_timeout($sformatf("cycle %0d never reached", n));
  endtask

  task automatic wait_tag(int tag);
    int guard = 0;
    while (op_live[tag] && guard < 100) begin
      @(posedge clock);
      guard++;
    end
    if (op_live[tag]) report_timeout($sformatf("tag %0d never appeared on cdb", tag));
  endtask

  task automatic wait_all_done();
    int guard = 0;
    while (live_count > 0 && guard < 300) begin
      @(posedge clock);
      guard++;
    end
    for (int t = 0; t < num_tags; t++) begin
      if (op_live[t]) begin
        report_timeout($sformatf("tag %0d never appeared on cdb", t));
        op_live[t] = 1'b0;  // drop it so later tests start clean
        live_count--;
      end
    end
  endtask

  task automatic after_reset();
    @(negedge clock);
    compare_cdb(cdb, '0, "cdb after reset");
    compare_hazard(rs_hazard, 1'b0, "rs_hazard after reset");
  endtask

  // a lone tag shows up 1 + latency edges after its dispatch edge
  task automatic single_ops();
    fu_type_t     kinds [3] = '{fu_alu, fu_mult, fu_mem};
    dispatch_op_t op;
    int           d;
    for (int k = 0; k < 3; k++) begin
      op = make_op(kinds[k], 10 + k, 0, 5 + k);
      send_op(op, d);
      idle_cycle();
      wait_until_cycle(d + unit_latency(kinds[k]));
      compare_cdb(cdb, '0, "cdb one cycle early");
      wait_until_cycle(d + 1 + unit_latency(kinds[k]));
      compare_cdb(cdb, {1'b1, op.dest}, $sformatf("lone %s op", kinds[k].name()));
      wait_all_done();
    end
    send_op(make_op(fu_alu, 14, 3, 4), d);  // back to back ops where mult and mem collide
    send_op(make_op(fu_alu, 15, 0, 0), d);
    send_op(make_op(fu_mult, 16, 0, 0), d);
    send_op(make_op(fu_mem, 17, 0, 0), d);
    idle_cycle();
    wait_all_done();
  endtask

  task automatic dependence_chain();
    int d;
    int e;
    send_op(make_op(fu_mult, 20, 0, 0), d);
    send_op(make_op(fu_alu, 21, 20, 0), e);
    idle_cycle();
    wait_tag(21);
    // tag 20 must already be off the in-flight list when 21 shows up
    if (op_live[20] || seen_cycle[21] <= seen_cycle[20]) begin
      report_error("alu tag 21 not after its mult source 20");
    end
    // alu dispatched while tag 22 is on the bus needs forwarding to wake
    send_op(make_op(fu_mult, 22, 0, 0), d);
    repeat (3) idle_cycle();
    send_op(make_op(fu_alu, 23, 0, 22), e);
    wait_until_cycle(d + 1 + unit_latency(fu_mult));
    compare_cdb(cdb, {1'b1, 6'd22}, "mult during forwarded dispatch");
    idle_cycle();
    wait_until_cycle(e + 1 + unit_latency(fu_alu));
    compare_cdb(cdb, {1'b1, 6'd23}, "alu on forwarded source");
    wait_all_done();
  endtask

  task automatic structural_hazard();
    int d;
    int e;
    send_op(make_op(fu_mult, 30, 0, 0), d);
    send_op(make_op(fu_alu, 31, 30, 0), e);
    send_op(make_op(fu_alu, 32, 0, 30), e);
    present_op(make_op(fu_alu, 33, 0, 0));  // both alu entries wait on 30
    wait_until_cycle(d + 3);                // mult still one cycle from the bus
    compare_hazard(rs_hazard, 1'b1, "third alu with both alu entries full");
    wait_tag(30);
    @(negedge clock);
    compare_hazard(rs_hazard, 1'b0, "alu after the mult broadcast");
    wait_all_done();
  endtask

  task automatic bus_contention();
    int d;
    int e;
    send_op(make_op(fu_mem, 40, 0, 0), d);  // mem due at d+3 and alu at e+2 = d+3
    send_op(make_op(fu_alu, 41, 0, 0), e);
    idle_cycle();
    wait_until_cycle(d + 3);
    compare_cdb(cdb, {1'b1, 6'd41}, "alu wins over mem");
    wait_until_cycle(d + 4);
    compare_cdb(cdb, {1'b1, 6'd40}, "mem one cycle later");
    wait_all_done();
    send_op(make_op(fu_mult, 42, 0, 0), d);  // all three due at d+4
    send_op(make_op(fu_mem, 43, 0, 0), e);
    send_op(make_op(fu_alu, 44, 0, 0), e);
    idle_cycle();
    wait_until_cycle(d + 4);
    compare_cdb(cdb, {1'b1, 6'd44}, "alu first of three");
    wait_until_cycle(d + 5);
    compare_cdb(cdb, {1'b1, 6'd42}, "mult second of three");
    wait_until_cycle(d + 6);
    compare_cdb(cdb, {1'b1, 6'd43}, "mem last of three");
    wait_all_done();
  endtask

  // a tag in flight half the time and otherwise any tag but the dest
  function automatic logic [tag_width-1:0] pick_source(int live [$],
                                                       logic [tag_width-1:0] dest);
    int t;
    if (live.size() > 0 && lfsr_bit()) begin
      return tag_width'(live[random_bits(4) % live.size()]);
    end
    t = random_bits(6);
    return (t == dest) ? '0 : tag_width'(t);
  endfunction

  task automatic random_stream();
    dispatch_op_t op;
    int           live [$];
    int           d;
    int           guard;
    for (int n = 0; n < 40; n++) begin
      live.delete();
      for (int t = 1; t < num_tags; t++) begin
        if (op_live[t]) live.push_back(t);
      end
      op.fu   = fu_type_t'(random_bits(2) % 3);  // code 3 folds onto alu
      op.func = func_width'(random_bits(4));
      op.dest = tag_width'(random_bits(6));
      while (op.dest == 0 || op_live[op.dest]) begin
        op.dest = op.dest + 1'b1;  // next free tag
      end
      op.src1 = pick_source(live, op.dest);
      op.src2 = pick_source(live, op.dest);
      present_op(op);
      guard = 0;
      @(negedge clock);
      while (rs_hazard && guard < 100) begin
        @(negedge clock);
        guard++;
      end
      if (rs_hazard) report_timeout($sformatf("rs_hazard stuck high for tag %0d", op.dest));
      send_op(op, d);
    end
    idle_cycle();
    wait_all_done();
  endtask

// File: verification/issue_cluster_tb.sv
`timescale 1ns/10ps

module issue_cluster_tb import rs_pkg::*; ();

  logic         clock = 1'b0;
  logic         reset;
  logic         dispatch_en;
  dispatch_op_t dispatch;
  logic         rs_hazard;
  cdb_t         cdb;

  int         cycle_cnt = 0;       // rising edges so far
  int         value_errors = 0;
  int         timeout_errors = 0;
  logic [7:0] lfsr_q = 8'd82;

  // scoreboard, indexed by dest tag
  bit                   op_live [num_tags];
  bit                   wait1 [num_tags];      // src1 not broadcast yet
  bit                   wait2 [num_tags];
  logic [tag_width-1:0] op_src1 [num_tags];
  logic [tag_width-1:0] op_src2 [num_tags];
  bit                   tag_ready [num_tags];  // expected ready table
  int                   seen_cycle [num_tags];
  int                   live_count = 0;

  issue_cluster i_issue_cluster (
    .clock       (clock),
    .reset       (reset),
    .dispatch_en (dispatch_en),
    .dispatch    (dispatch),
    .rs_hazard   (rs_hazard),
    .cdb         (cdb)
  );

  always #10 clock = ~clock;  // 20 ns period

  always @(posedge clock) cycle_cnt <= cycle_cnt + 1;

  // x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic lfsr_bit();
    logic fb;
    fb     = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];
    lfsr_q = {lfsr_q[6:0], fb};
    return fb;
  endfunction

  function automatic int random_bits(int n);
    int v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | lfsr_bit();  // one step per bit
    end
    return v;
  endfunction

  // unit depth per class, alu 1, mult 3, mem 2
  function automatic int unit_latency(fu_type_t fu);
    case (fu)
      fu_mult: return 3;
      fu_mem:  return 2;
      default: return 1;
    endcase
  endfunction

  task automatic report_error(string msg);
    value_errors++;
    $display("[ERROR] %0t: %s", $time, msg);
  endtask

  task automatic report_timeout(string msg);
    timeout_errors++;
    $display("Timed out at %0t: %s", $time, msg);
  endtask

  task automatic compare_cdb(cdb_t actual, cdb_t expected, string what);
    if (actual.valid !== expected.valid ||
        (expected.valid && actual.tag !== expected.tag)) begin
      report_error($sformatf("%s: cdb valid %b tag %0d, expected valid %b tag %0d",
                             what, actual.valid, actual.tag, expected.valid, expected.tag));
    end
  endtask

  task automatic compare_hazard(logic actual, logic expected, string what);
    if (actual !== expected) begin
      report_error($sformatf("%s: rs_hazard %b, expected %b", what, actual, expected));
    end
  endtask

  // every broadcast must be a live tag whose sources came first
  task automatic note_broadcast(logic [tag_width-1:0] t);
    if (!op_live[t]) begin
      report_error($sformatf("tag %0d on cdb but not in flight", t));
    end else begin
      if (wait1[t] || wait2[t]) begin
        report_error($sformatf("tag %0d on cdb before its sources", t));
      end
      live_count--;
    end
    op_live[t]    = 1'b0;
    tag_ready[t]  = 1'b1;
    seen_cycle[t] = cycle_cnt;
    for (int i = 0; i < num_tags; i++) begin
      if (op_live[i] && op_src1[i] == t) wait1[i] = 1'b0;  // consumer woken
      if (op_live[i] && op_src2[i] == t) wait2[i] = 1'b0;
    end
  endtask

  always @(negedge clock) begin
    if (!reset && cdb.valid) begin
      note_broadcast(cdb.tag);
    end
  end

  `include "issue_cluster_tests.svh"

  initial begin
    reset       = 1'b1;
    dispatch_en = 1'b0;
    dispatch    = '0;
    for (int t = 0; t < num_tags; t++) begin
      tag_ready[t] = 1'b1;  // all tags ready out of reset
    end
    repeat (5) @(posedge clock);
    reset <= 1'b0;

    after_reset();
    single_ops();
    dependence_chain();
    structural_hazard();
    bus_contention();
    random_stream();

    $display("%0d value errors, %0d timeouts", value_errors, timeout_errors);
    if (value_errors + timeout_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: src/issue_cluster.sv
`timescale 1ns/10ps

module issue_cluster import rs_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  logic         dispatch_en,  // one op per cycle, only while rs_hazard is low
  input  dispatch_op_t dispatch,
  output logic         rs_hazard,
  output cdb_t         cdb           // result broadcast, wakes table and rs
);

  logic                src1_ready;
  logic                src2_ready;
  issue_t [num_fu-1:0] issue;        // rs to units
  logic   [num_fu-1:0] done;         // units to rs
  cdb_t   [num_fu-1:0] finish;       // units to arbiter
  logic   [num_fu-1:0] grant;        // arbiter to units

  tag_ready_table i_tag_ready_table (
    .clock       (clock),
    .reset       (reset),
    .dispatch_en (dispatch_en),
    .dispatch    (dispatch),
    .cdb         (cdb),
    .src1_ready  (src1_ready),
    .src2_ready  (src2_ready)
  );

  rs i_rs (
    .clock       (clock),
    .reset       (reset),
    .dispatch_en (dispatch_en),
    .dispatch    (dispatch),
    .src1_ready  (src1_ready),
    .src2_ready  (src2_ready),
    .cdb         (cdb),
    .done        (done),
    .issue       (issue),
    .rs_hazard   (rs_hazard)
  );

  // one pipeline per rs entry, depth from the unit table
  for (genvar i = 0; i < num_fu; i++) begin : g_fu
    fu_pipe #(.latency(fu_latency[i])) i_fu_pipe (
      .clock  (clock),
      .reset  (reset),
      .issue  (issue[i]),
      .grant  (grant[i]),
      .done   (done[i]),
      .finish (finish[i])
    );
  end

  cdb_arbiter i_cdb_arbiter (
    .finish (finish),
    .grant  (grant),
    .cdb    (cdb)
  );

endmodule

// File: src/cdb_arbiter.sv
`timescale 1ns/10ps

module cdb_arbiter import rs_pkg::*; (
  input  cdb_t [num_fu-1:0] finish,  // completion offered by each unit
  output logic [num_fu-1:0] grant,
  output cdb_t              cdb      // the one broadcast of this cycle
);

  logic taken;  // a lower unit already owns the bus

  always_comb begin
    grant = '0;
    cdb   = '0;
    taken = 1'b0;

    // unit 0 has the highest priority
    for (int i = 0; i < num_fu; i++) begin
      if (finish[i].valid && !taken) begin
        grant[i]  = 1'b1;
        cdb.valid = 1'b1;
        cdb.tag   = finish[i].tag;
        taken     = 1'b1;
      end
    end
  end

endmodule

// File: src/fu_pipe.sv
`timescale 1ns/10ps

module fu_pipe import rs_pkg::*; #(
  parameter int latency = 1  // stages, 1 or more
) (
  input  logic   clock,
  input  logic   reset,
  input  issue_t issue,
  input  logic   grant,  // bus takes the last stage this cycle
  output logic   done,   // issue accepted at this edge
  output cdb_t   finish
);

  logic [latency-1:0]                valid_q;  // stage occupancy
  logic [latency-1:0][tag_width-1:0] tag_q;    // dest tag per stage
  logic                              hold;     // finished op not granted yet

  assign hold = valid_q[latency-1] && !grant;
  assign done = !hold;  // whole pipe freezes behind a blocked result

  assign finish.valid = valid_q[latency-1];
  assign finish.tag   = tag_q[latency-1];

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= '0;
    end else if (!hold) begin
      valid_q[0] <= issue.valid;  // a bubble when nothing is offered
      for (int k = 1; k < latency; k++) begin
        valid_q[k] <= valid_q[k-1];
      end
    end
  end

  // tags ride along, qualified by valid_q
  always_ff @(posedge clock) begin
    if (!hold) begin
      tag_q[0] <= issue.dest;
      for (int k = 1; k < latency; k++) begin
        tag_q[k] <= tag_q[k-1];
      end
    end
  end

endmodule

// File: src/rs.sv
`timescale 1ns/10ps

module rs import rs_pkg::*; (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  dispatch_en,
  input  dispatch_op_t          dispatch,
  input  logic                  src1_ready,  // from the ready table, cdb forwarded
  input  logic                  src2_ready,
  input  cdb_t                  cdb,
  input  logic   [num_fu-1:0]   done,        // unit can take an issue this cycle
  output issue_t [num_fu-1:0]   issue,
  output logic                  rs_hazard
);

  rs_entry_t [num_fu-1:0] entry_q;
  rs_entry_t [num_fu-1:0] entry_d;
  logic      [num_fu-1:0] t1_cdb;       // stored t1 matches the broadcast
  logic      [num_fu-1:0] t2_cdb;
  logic      [num_fu-1:0] t1_ok;
  logic      [num_fu-1:0] t2_ok;
  logic      [num_fu-1:0] entry_ready;  // both operands available
  logic      [num_fu-1:0] entry_go;     // issuing at this edge
  logic      [num_fu-1:0] entry_free;   // empty or emptying
  logic      [num_fu-1:0] entry_match;  // free and bound to the dispatched type
  logic                   placed;       // dispatch already written to an entry

  always_comb begin
    for (int i = 0; i < num_fu; i++) begin
      // each source wakes on its own tag
      t1_cdb[i]      = cdb.valid && (entry_q[i].t1.tag == cdb.tag);
      t2_cdb[i]      = cdb.valid && (entry_q[i].t2.tag == cdb.tag);
      t1_ok[i]       = entry_q[i].t1.ready || t1_cdb[i];
      t2_ok[i]       = entry_q[i].t2.ready || t2_cdb[i];
      entry_ready[i] = entry_q[i].busy && t1_ok[i] && t2_ok[i];
      entry_go[i]    = entry_ready[i] && done[i];          // unit takes it now
      entry_free[i]  = !entry_q[i].busy || entry_go[i];    // reusable this cycle
      entry_match[i] = entry_free[i] && (fu_list[i] == dispatch.fu);

      issue[i].valid = entry_ready[i];   // offered even if the unit is stalled
      issue[i].func  = entry_q[i].func;
      issue[i].dest  = entry_q[i].dest;
    end
  end

  // no slot of the requested class can be had this cycle
  assign rs_hazard = (entry_match == '0);

  always_comb begin
    entry_d = entry_q;
    placed  = 1'b0;

    for (int i = 0; i < num_fu; i++) begin
      if (t1_cdb[i]) begin
        entry_d[i].t1.ready = 1'b1;
      end
      if (t2_cdb[i]) begin
        entry_d[i].t2.ready = 1'b1;
      end
      if (entry_go[i]) begin
        entry_d[i].busy = 1'b0;  // handed to the unit
      end
    end

    // lowest matching entry takes the new op
    if (dispatch_en) begin
      for (int i = 0; i < num_fu; i++) begin
        if (entry_match[i] && !placed) begin
          entry_d[i].busy     = 1'b1;
          entry_d[i].func     = dispatch.func;
          entry_d[i].dest     = dispatch.dest;
          entry_d[i].t1.tag   = dispatch.src1;
          entry_d[i].t1.ready = src1_ready;
          entry_d[i].t2.tag   = dispatch.src2;
          entry_d[i].t2.ready = src2_ready;
          placed              = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      entry_q <= '0;  // all slots empty
    end else begin
      entry_q <= entry_d;
    end
  end

endmodule

// File: src/tag_ready_table.sv
`timescale 1ns/10ps

module tag_ready_table import rs_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  logic         dispatch_en,  // accepted dispatch, front end honours rs_hazard
  input  dispatch_op_t dispatch,
  input  cdb_t         cdb,
  output logic         src1_ready,
  output logic         src2_ready
);

  logic [num_tags-1:0] ready_q;  // one bit per physical tag
  logic                src1_fwd;
  logic                src2_fwd;

  // a tag on the bus this cycle counts as ready already
  assign src1_fwd = cdb.valid && (cdb.tag == dispatch.src1);
  assign src2_fwd = cdb.valid && (cdb.tag == dispatch.src2);

  assign src1_ready = ready_q[dispatch.src1] || src1_fwd;
  assign src2_ready = ready_q[dispatch.src2] || src2_fwd;

  always_ff @(posedge clock) begin
    if (reset) begin
      ready_q <= '1;  // everything architected at reset
    end else begin
      if (cdb.valid) begin
        ready_q[cdb.tag] <= 1'b1;  // producer finished
      end
      // new producer, pending until its broadcast
      // written second so a reallocated tag stays pending
      if (dispatch_en && (dispatch.dest != '0)) begin
        ready_q[dispatch.dest] <= 1'b0;
      end
    end
  end

endmodule

// File: src/rs_pkg.sv
package rs_pkg;

  localparam int tag_width  = 6;               // physical tag width
  localparam int num_tags   = 2 ** tag_width;  // 64 physical tags, tag 0 always ready
  localparam int num_fu     = 4;               // functional units, one rs entry each
  localparam int func_width = 4;               // function code width

  // unit classes, value 3 is unused
  typedef enum logic [1:0] {
    fu_alu,
    fu_mult,
    fu_mem
  } fu_type_t;

  // unit order fixes both the rs entry binding and the cdb priority
  localparam fu_type_t fu_list [num_fu] = '{fu_alu, fu_alu, fu_mult, fu_mem};
  localparam int fu_latency [num_fu] = '{1, 1, 3, 2};  // pipeline depth per unit

  // source operand as held in an rs entry
  typedef struct packed {
    logic [tag_width-1:0] tag;    // physical source tag
    logic                 ready;  // value produced already
  } src_tag_t;

  // one operation from the front end
  typedef struct packed {
    fu_type_t              fu;    // unit class it needs
    logic [func_width-1:0] func;
    logic [tag_width-1:0]  dest;  // renamed destination
    logic [tag_width-1:0]  src1;
    logic [tag_width-1:0]  src2;
  } dispatch_op_t;

  // reservation station slot
  typedef struct packed {
    logic                  busy;  // slot holds a waiting op
    logic [func_width-1:0] func;
    logic [tag_width-1:0]  dest;
    src_tag_t              t1;
    src_tag_t              t2;
  } rs_entry_t;

  // rs to unit pipeline
  typedef struct packed {
    logic                  valid;  // both sources ready
    logic [func_width-1:0] func;
    logic [tag_width-1:0]  dest;
  } issue_t;

  // completion, used for unit finish and for the broadcast bus
  typedef struct packed {
    logic                 valid;
    logic [tag_width-1:0] tag;
  } cdb_t;

endpackage
